// File: Bender.yml
package:
  name: axil_mux

sources:
  - include_dirs:
      - design
    files:
      - design/axil_mux_pkg.sv
      - design/axil_rr_arbiter.sv
      - design/axil_idx_fifo.sv
      - design/axil_write_mux.sv
      - design/axil_read_mux.sv
      - design/axil_mux_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/axil_sub_model.sv
      - sim/tb_axil_mux.sv

// File: design/axil_idx_fifo.sv
/*
 * Index FIFO
 * Circular buffer of port numbers, keeps the order in which
 * transactions were granted
 */

`include "axil_mux_consts.svh"

module axil_idx_fifo import axil_mux_pkg::*; #(
  parameter int unsigned DEPTH = `MAX_TRANS
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  port_idx_t data_i,
  input  logic      pop_i,
  output port_idx_t data_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Storage
  port_idx_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // Head entry, valid while not empty
  assign data_o  = mem[rd_ptr_q];

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        // Wrap explicitly, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry write
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow:  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

// File: design/axil_mux_consts.svh
/*
 * AXI4-Lite multiplexer constants
 * Port count, bus widths, outstanding depth and response codes
 */

`ifndef AXIL_MUX_CONSTS_SVH
`define AXIL_MUX_CONSTS_SVH

// Manager ports merged onto the one subordinate port
`define NUM_PORTS 4

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// Outstanding transactions per direction, also the index FIFO depth
`define MAX_TRANS 4

// Width of a port number
`define IDX_W $clog2(`NUM_PORTS)

// AXI response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: design/axil_mux_pkg.sv
/*
 * AXI4-Lite multiplexer package
 * Width types shared by the arbiter, the FIFOs and the muxes
 */

`include "axil_mux_consts.svh"

package axil_mux_pkg;

  // Port number, selects one manager port
  typedef logic [`IDX_W-1:0] port_idx_t;

  // Address and protection of AW and AR
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [2:0]         prot_t;

  // Write and read data
  typedef logic [`DATA_W-1:0]   data_t;
  // One strobe bit per byte lane
  typedef logic [`DATA_W/8-1:0] strb_t;

  // B and R response code
  typedef logic [1:0] resp_t;

endpackage

// File: design/axil_mux_top.sv
/*
 * AXI4-Lite multiplexer top
 * Joins the write and read path muxes, which share no state
 */

`include "axil_mux_consts.svh"

module axil_mux_top import axil_mux_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Manager ports
  input  logic  s_awvalid_i [`NUM_PORTS],
  output logic  s_awready_o [`NUM_PORTS],
  input  addr_t s_awaddr_i  [`NUM_PORTS],
  input  prot_t s_awprot_i  [`NUM_PORTS],
  input  logic  s_wvalid_i  [`NUM_PORTS],
  output logic  s_wready_o  [`NUM_PORTS],
  input  data_t s_wdata_i   [`NUM_PORTS],
  input  strb_t s_wstrb_i   [`NUM_PORTS],
  output logic  s_bvalid_o  [`NUM_PORTS],
  input  logic  s_bready_i  [`NUM_PORTS],
  output resp_t s_bresp_o   [`NUM_PORTS],
  input  logic  s_arvalid_i [`NUM_PORTS],
  output logic  s_arready_o [`NUM_PORTS],
  input  addr_t s_araddr_i  [`NUM_PORTS],
  input  prot_t s_arprot_i  [`NUM_PORTS],
  output logic  s_rvalid_o  [`NUM_PORTS],
  input  logic  s_rready_i  [`NUM_PORTS],
  output data_t s_rdata_o   [`NUM_PORTS],
  output resp_t s_rresp_o   [`NUM_PORTS],
  // Subordinate port
  output logic  m_awvalid_o,
  input  logic  m_awready_i,
  output addr_t m_awaddr_o,
  output prot_t m_awprot_o,
  output logic  m_wvalid_o,
  input  logic  m_wready_i,
  output data_t m_wdata_o,
  output strb_t m_wstrb_o,
  input  logic  m_bvalid_i,
  output logic  m_bready_o,
  input  resp_t m_bresp_i,
  output logic  m_arvalid_o,
  input  logic  m_arready_i,
  output addr_t m_araddr_o,
  output prot_t m_arprot_o,
  input  logic  m_rvalid_i,
  output logic  m_rready_o,
  input  data_t m_rdata_i,
  input  resp_t m_rresp_i
);

  // Write path, AW W B
  axil_write_mux i_write_mux (
    .clk_i, .rst_n_i,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i, .s_awprot_i,
    .s_wvalid_i,  .s_wready_o,  .s_wdata_i,  .s_wstrb_i,
    .s_bvalid_o,  .s_bready_i,  .s_bresp_o,
    .m_awvalid_o, .m_awready_i, .m_awaddr_o, .m_awprot_o,
    .m_wvalid_o,  .m_wready_i,  .m_wdata_o,  .m_wstrb_o,
    .m_bvalid_i,  .m_bready_o,  .m_bresp_i
  );

  // Read path, AR R
  axil_read_mux i_read_mux (
    .clk_i, .rst_n_i,
    .s_arvalid_i, .s_arready_o, .s_araddr_i, .s_arprot_i,
    .s_rvalid_o,  .s_rready_i,  .s_rdata_o,  .s_rresp_o,
    .m_arvalid_o, .m_arready_i, .m_araddr_o, .m_arprot_o,
    .m_rvalid_i,  .m_rready_o,  .m_rdata_i,  .m_rresp_i
  );

endmodule

// File: design/axil_read_mux.sv
/*
 * AXI4-Lite read path multiplexer
 * Arbitrates AR round robin and routes each R back in order
 */

`include "axil_mux_consts.svh"

module axil_read_mux import axil_mux_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Manager ports
  input  logic  s_arvalid_i [`NUM_PORTS],
  output logic  s_arready_o [`NUM_PORTS],
  input  addr_t s_araddr_i  [`NUM_PORTS],
  input  prot_t s_arprot_i  [`NUM_PORTS],
  output logic  s_rvalid_o  [`NUM_PORTS],
  input  logic  s_rready_i  [`NUM_PORTS],
  output data_t s_rdata_o   [`NUM_PORTS],
  output resp_t s_rresp_o   [`NUM_PORTS],
  // Subordinate port
  output logic  m_arvalid_o,
  input  logic  m_arready_i,
  output addr_t m_araddr_o,
  output prot_t m_arprot_o,
  input  logic  m_rvalid_i,
  output logic  m_rready_o,
  input  data_t m_rdata_i,
  input  resp_t m_rresp_i
);

  // Arbiter handshake
  logic      ar_valid, ar_ready;
  port_idx_t ar_idx;
  // R FIFO in order of AR transfers
  logic      r_fifo_push, r_fifo_pop, r_fifo_full, r_fifo_empty;
  port_idx_t r_sel;

  // --------------------
  // AR channel
  // --------------------
  axil_rr_arbiter i_ar_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (s_arvalid_i),
    .gnt_o   (s_arready_o),
    .addr_i  (s_araddr_i),
    .prot_i  (s_arprot_i),
    .valid_o (ar_valid),
    .ready_i (ar_ready),
    .addr_o  (m_araddr_o),
    .prot_o  (m_arprot_o),
    .idx_o   (ar_idx)
  );

  // AR held back while the R FIFO is full
  assign m_arvalid_o = ar_valid && !r_fifo_full;
  assign ar_ready    = m_arready_i && !r_fifo_full;
  assign r_fifo_push = m_arvalid_o && m_arready_i;

  axil_idx_fifo r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (r_fifo_push),
    .data_i  (ar_idx),
    .pop_i   (r_fifo_pop),
    .data_o  (r_sel),
    .full_o  (r_fifo_full),
    .empty_o (r_fifo_empty)
  );

  // --------------------
  // R channel
  // --------------------
  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_r_out
    assign s_rvalid_o[p] = m_rvalid_i && !r_fifo_empty && (r_sel == port_idx_t'(p));
    assign s_rdata_o[p]  = m_rdata_i;
    assign s_rresp_o[p]  = m_rresp_i;
  end
  assign m_rready_o = !r_fifo_empty && s_rready_i[r_sel];
  assign r_fifo_pop = m_rvalid_i && m_rready_o;

  // Every R from the subordinate answers a recorded AR
  a_r_has_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_rvalid_i |-> !r_fifo_empty);

endmodule

// File: design/axil_rr_arbiter.sv
/*
 * Round-robin address arbiter
 * Picks the next requesting port after the last winner and holds
 * the choice until the downstream side accepts the address
 */

`include "axil_mux_consts.svh"

module axil_rr_arbiter import axil_mux_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Request side, one entry per port
  input  logic      req_i  [`NUM_PORTS],
  output logic      gnt_o  [`NUM_PORTS],
  input  addr_t     addr_i [`NUM_PORTS],
  input  prot_t     prot_i [`NUM_PORTS],
  // Winner side
  output logic      valid_o,
  input  logic      ready_i,
  output addr_t     addr_o,
  output prot_t     prot_o,
  output port_idx_t idx_o
);

  // Last port that transferred, rotation starts after it
  port_idx_t last_q;
  // Lock on a stalled offer
  logic      lock_q;
  port_idx_t lock_idx_q;
  // Fresh round-robin pick
  port_idx_t rr_idx;
  logic      rr_found;

  // --------------------
  // Round-robin pick
  // --------------------
  always_comb begin : p_pick
    port_idx_t cand;
    rr_idx   = last_q;
    rr_found = 1'b0;
    cand     = last_q;
    // Scan from the port after the last winner, wrapping around
    for (int unsigned i = 1; i <= `NUM_PORTS; i++) begin
      cand = port_idx_t'((last_q + i) % `NUM_PORTS);
      if (!rr_found && req_i[cand]) begin
        rr_idx   = cand;
        rr_found = 1'b1;
      end
    end
  end

  // Locked choice wins over a fresh pick
  assign idx_o   = lock_q ? lock_idx_q : rr_idx;
  assign valid_o = lock_q ? req_i[lock_idx_q] : rr_found;
  assign addr_o  = addr_i[idx_o];
  assign prot_o  = prot_i[idx_o];

  // Grant only the winner, and only on the transfer
  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_gnt
    assign gnt_o[p] = valid_o && ready_i && (idx_o == port_idx_t'(p));
  end

  // --------------------
  // State
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Port 0 comes first after reset
      last_q     <= port_idx_t'(`NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= valid_o && !ready_i;
      if (!lock_q) begin
        lock_idx_q <= rr_idx;
      end
      if (valid_o && ready_i) begin
        last_q <= idx_o;
      end
    end
  end

  // Offer stays put while stalled, as long as the managers follow AXI
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(addr_o) && $stable(idx_o));

endmodule

// File: design/axil_write_mux.sv
/*
 * AXI4-Lite write path multiplexer
 * Arbitrates AW round robin, steers W in grant order and
 * returns each B to the port that issued the write
 */

`include "axil_mux_consts.svh"

module axil_write_mux import axil_mux_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Manager ports
  input  logic  s_awvalid_i [`NUM_PORTS],
  output logic  s_awready_o [`NUM_PORTS],
  input  addr_t s_awaddr_i  [`NUM_PORTS],
  input  prot_t s_awprot_i  [`NUM_PORTS],
  input  logic  s_wvalid_i  [`NUM_PORTS],
  output logic  s_wready_o  [`NUM_PORTS],
  input  data_t s_wdata_i   [`NUM_PORTS],
  input  strb_t s_wstrb_i   [`NUM_PORTS],
  output logic  s_bvalid_o  [`NUM_PORTS],
  input  logic  s_bready_i  [`NUM_PORTS],
  output resp_t s_bresp_o   [`NUM_PORTS],
  // Subordinate port
  output logic  m_awvalid_o,
  input  logic  m_awready_i,
  output addr_t m_awaddr_o,
  output prot_t m_awprot_o,
  output logic  m_wvalid_o,
  input  logic  m_wready_i,
  output data_t m_wdata_o,
  output strb_t m_wstrb_o,
  input  logic  m_bvalid_i,
  output logic  m_bready_o,
  input  resp_t m_bresp_i
);

  // Arbiter handshake gated by the W FIFO
  logic      aw_valid, aw_ready;
  port_idx_t aw_idx;
  // AW valid lock against a second push for a stalled AW
  logic      lock_q, lock_d;
  // W FIFO in order of AW grants
  logic      w_fifo_push, w_fifo_pop, w_fifo_full, w_fifo_empty;
  port_idx_t w_sel;
  // B FIFO in order of W transfers
  logic      b_fifo_pop, b_fifo_full, b_fifo_empty;
  port_idx_t b_sel;
  // W may pass
  logic      w_open;

  // --------------------
  // AW channel
  // --------------------
  axil_rr_arbiter i_aw_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (s_awvalid_i),
    .gnt_o   (s_awready_o),
    .addr_i  (s_awaddr_i),
    .prot_i  (s_awprot_i),
    .valid_o (aw_valid),
    .ready_i (aw_ready),
    .addr_o  (m_awaddr_o),
    .prot_o  (m_awprot_o),
    .idx_o   (aw_idx)
  );

  always_comb begin
    lock_d      = lock_q;
    w_fifo_push = 1'b0;
    m_awvalid_o = 1'b0;
    aw_ready    = 1'b0;
    if (lock_q) begin
      // Index already pushed so just wait for the transfer
      m_awvalid_o = 1'b1;
      if (m_awready_i) begin
        aw_ready = 1'b1;
        lock_d   = 1'b0;
      end
    end else if (aw_valid && !w_fifo_full) begin
      // First offer records the winner for W
      m_awvalid_o = 1'b1;
      w_fifo_push = 1'b1;
      if (m_awready_i) begin
        aw_ready = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  axil_idx_fifo w_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_fifo_push),
    .data_i  (aw_idx),
    .pop_i   (w_fifo_pop),
    .data_o  (w_sel),
    .full_o  (w_fifo_full),
    .empty_o (w_fifo_empty)
  );

  // --------------------
  // W channel
  // --------------------
  // Head port only and only with room for its B
  assign w_open     = !w_fifo_empty && !b_fifo_full;
  assign m_wvalid_o = w_open && s_wvalid_i[w_sel];
  assign m_wdata_o  = s_wdata_i[w_sel];
  assign m_wstrb_o  = s_wstrb_i[w_sel];
  assign w_fifo_pop = m_wvalid_o && m_wready_i;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_w_ready
    assign s_wready_o[p] = m_wready_i && w_open && (w_sel == port_idx_t'(p));
  end

  // Index moves on to the B FIFO with each W transfer
  axil_idx_fifo b_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_fifo_pop),
    .data_i  (w_sel),
    .pop_i   (b_fifo_pop),
    .data_o  (b_sel),
    .full_o  (b_fifo_full),
    .empty_o (b_fifo_empty)
  );

  // --------------------
  // B channel
  // --------------------
  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_b_out
    assign s_bvalid_o[p] = m_bvalid_i && !b_fifo_empty && (b_sel == port_idx_t'(p));
    assign s_bresp_o[p]  = m_bresp_i;
  end
  assign m_bready_o = !b_fifo_empty && s_bready_i[b_sel];
  assign b_fifo_pop = m_bvalid_i && m_bready_o;

  // Every B from the subordinate answers a write whose W has gone out
  a_b_has_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_bvalid_i |-> !b_fifo_empty);

endmodule

// File: project.f
+incdir+design
design/axil_mux_pkg.sv
design/axil_rr_arbiter.sv
design/axil_idx_fifo.sv
design/axil_write_mux.sv
design/axil_read_mux.sv
design/axil_mux_top.sv
sim/axil_sub_model.sv
sim/tb_axil_mux.sv

// File: sim/axil_sub_model.sv
/*
 * Behavioral AXI4-Lite subordinate
 * 256-word memory with random ready stalls and response delays,
 * SLVERR for any address with bit 31 set
 */

`include "axil_mux_consts.svh"

module axil_sub_model import axil_mux_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  awvalid_i,
  output logic  awready_o,
  input  addr_t awaddr_i,
  input  logic  wvalid_i,
  output logic  wready_o,
  input  data_t wdata_i,
  input  strb_t wstrb_i,
  output logic  bvalid_o,
  input  logic  bready_i,
  output resp_t bresp_o,
  input  logic  arvalid_i,
  output logic  arready_o,
  input  addr_t araddr_i,
  output logic  rvalid_o,
  input  logic  rready_i,
  output data_t rdata_o,
  output resp_t rresp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  data_t mem [256];
  // Accepted but not yet answered
  addr_t aw_q [$];
  data_t wd_q [$];
  strb_t ws_q [$];
  addr_t ar_q [$];
  logic [31:0] lfsr_q;

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  always @(posedge clk_i or negedge rst_n_i) begin : p_model
    addr_t a;
    data_t d;
    strb_t s;
    if (!rst_n_i) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bresp_o   <= `RESP_OKAY;
      rresp_o   <= `RESP_OKAY;
      rdata_o   <= '0;
      lfsr_q    = 32'h6808;
      aw_q.delete();
      wd_q.delete();
      ws_q.delete();
      ar_q.delete();
      for (int i = 0; i < 256; i++) begin
        mem[i] = '0;
      end
    end else begin
      // --------------------
      // Address and data intake
      if (awvalid_i && awready_o) aw_q.push_back(awaddr_i);
      if (wvalid_i && wready_o) begin
        wd_q.push_back(wdata_i);
        ws_q.push_back(wstrb_i);
      end
      if (arvalid_i && arready_o) ar_q.push_back(araddr_i);
      // About half of the cycles stall, queues hold at most 4
      awready_o <= next_bit() && (aw_q.size() < 4);
      wready_o  <= next_bit() && (wd_q.size() < 4);
      arready_o <= next_bit() && (ar_q.size() < 4);

      // --------------------
      // Write response, one in four cycles when ready to go
      if (bvalid_o && bready_i) bvalid_o <= 1'b0;
      if ((!bvalid_o || bready_i) && aw_q.size() > 0 && wd_q.size() > 0 &&
          next_bit() && next_bit()) begin
        a = aw_q.pop_front();
        d = wd_q.pop_front();
        s = ws_q.pop_front();
        if (!a[31]) begin
          for (int b = 0; b < `DATA_W / 8; b++) begin
            if (s[b]) mem[a[9:2]][8*b +: 8] = d[8*b +: 8];
          end
        end
        bvalid_o <= 1'b1;
        bresp_o  <= a[31] ? `RESP_SLVERR : `RESP_OKAY;
      end

      // Read data, same pacing
      if (rvalid_o && rready_i) rvalid_o <= 1'b0;
      if ((!rvalid_o || rready_i) && ar_q.size() > 0 && next_bit() && next_bit()) begin
        a = ar_q.pop_front();
        rvalid_o <= 1'b1;
        rdata_o  <= a[31] ? '0 : mem[a[9:2]];
        rresp_o  <= a[31] ? `RESP_SLVERR : `RESP_OKAY;
      end
    end
  end

endmodule

// File: sim/tb_axil_mux.sv
/*
 * Testbench for the AXI4-Lite multiplexer
 * Four manager processes, a subordinate model, a read checker
 * against a shadow memory, routing and fairness monitors
 */

`include "axil_mux_consts.svh"

module tb_axil_mux import axil_mux_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N_PER_PORT = 40;
  localparam int unsigned N_TRANS    = 2 + `NUM_PORTS * N_PER_PORT * 2;
  localparam int unsigned WD_CYCLES  = N_TRANS * 64 + 1000;

  logic  clk, rst_n;
  logic  s_awvalid [`NUM_PORTS], s_awready [`NUM_PORTS];
  addr_t s_awaddr [`NUM_PORTS], s_araddr [`NUM_PORTS];
  prot_t s_awprot [`NUM_PORTS], s_arprot [`NUM_PORTS];
  logic  s_wvalid [`NUM_PORTS], s_wready [`NUM_PORTS];
  data_t s_wdata [`NUM_PORTS], s_rdata [`NUM_PORTS];
  strb_t s_wstrb [`NUM_PORTS];
  logic  s_bvalid [`NUM_PORTS], s_bready [`NUM_PORTS];
  resp_t s_bresp [`NUM_PORTS], s_rresp [`NUM_PORTS];
  logic  s_arvalid [`NUM_PORTS], s_arready [`NUM_PORTS];
  logic  s_rvalid [`NUM_PORTS], s_rready [`NUM_PORTS];
  logic  m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic  m_arvalid, m_arready, m_rvalid, m_rready;
  addr_t m_awaddr, m_araddr;
  prot_t m_awprot, m_arprot;
  data_t m_wdata, m_rdata;
  strb_t m_wstrb;
  resp_t m_bresp, m_rresp;

  // Checker state
  int unsigned err_cnt, writes_done, reads_checked;
  int          wr_out, rd_out, wr_max, rd_max;
  logic        pend_w [`NUM_PORTS], pend_r [`NUM_PORTS];
  bit          skip [`NUM_PORTS][`NUM_PORTS];
  data_t       shadow [256];
  int          rd_port_q [$];
  addr_t       rd_addr_q [$];
  data_t       rd_data_q [$];
  resp_t       rd_resp_q [$];
  // Ports in the order their addresses were granted
  int          aw_port_q [$];
  int          ar_port_q [$];
  logic [31:0] lfsr_state = 32'h6808;

  axil_mux_top uut (
    .clk_i (clk), .rst_n_i (rst_n),
    .s_awvalid_i (s_awvalid), .s_awready_o (s_awready), .s_awaddr_i (s_awaddr),
    .s_awprot_i (s_awprot), .s_wvalid_i (s_wvalid), .s_wready_o (s_wready),
    .s_wdata_i (s_wdata), .s_wstrb_i (s_wstrb), .s_bvalid_o (s_bvalid),
    .s_bready_i (s_bready), .s_bresp_o (s_bresp), .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready), .s_araddr_i (s_araddr), .s_arprot_i (s_arprot),
    .s_rvalid_o (s_rvalid), .s_rready_i (s_rready), .s_rdata_o (s_rdata),
    .s_rresp_o (s_rresp),
    .m_awvalid_o (m_awvalid), .m_awready_i (m_awready), .m_awaddr_o (m_awaddr),
    .m_awprot_o (m_awprot), .m_wvalid_o (m_wvalid), .m_wready_i (m_wready),
    .m_wdata_o (m_wdata), .m_wstrb_o (m_wstrb), .m_bvalid_i (m_bvalid),
    .m_bready_o (m_bready), .m_bresp_i (m_bresp), .m_arvalid_o (m_arvalid),
    .m_arready_i (m_arready), .m_araddr_o (m_araddr), .m_arprot_o (m_arprot),
    .m_rvalid_i (m_rvalid), .m_rready_o (m_rready), .m_rdata_i (m_rdata),
    .m_rresp_i (m_rresp)
  );

  axil_sub_model i_sub (
    .clk_i (clk), .rst_n_i (rst_n),
    .awvalid_i (m_awvalid), .awready_o (m_awready), .awaddr_i (m_awaddr),
    .wvalid_i (m_wvalid), .wready_o (m_wready), .wdata_i (m_wdata), .wstrb_i (m_wstrb),
    .bvalid_o (m_bvalid), .bready_i (m_bready), .bresp_o (m_bresp),
    .arvalid_i (m_arvalid), .arready_o (m_arready), .araddr_i (m_araddr),
    .rvalid_o (m_rvalid), .rready_i (m_rready), .rdata_o (m_rdata), .rresp_o (m_rresp)
  );

  always #2 clk = ~clk;

  // --------------------
  // Random numbers
  function automatic logic next_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Expected {resp, data} of a read from the shadow memory
  function automatic logic [33:0] expected_read(input addr_t addr);
    if (addr[31]) return {`RESP_SLVERR, 32'h0};
    return {`RESP_OKAY, shadow[addr[9:2]]};
  endfunction

  // --------------------
  // Manager transactions
  task automatic do_write(input int p, input addr_t addr, input data_t data, input strb_t strb);
    logic  aw_done, w_done, b_done;
    resp_t resp;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    @(posedge clk);
    s_awvalid[p] <= 1'b1;
    s_awaddr[p]  <= addr;
    s_awprot[p]  <= addr[4:2];
    s_wvalid[p]  <= 1'b1;
    s_wdata[p]   <= data;
    s_wstrb[p]   <= strb;
    pend_w[p]    <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (s_awvalid[p] && s_awready[p]) begin
        s_awvalid[p] <= 1'b0;
        aw_done = 1'b1;
      end
      if (s_wvalid[p] && s_wready[p]) begin
        s_wvalid[p] <= 1'b0;
        w_done = 1'b1;
      end
    end
    // Randomly stalled B acceptance
    while (!b_done) begin
      @(posedge clk);
      if (s_bvalid[p] && s_bready[p]) begin
        resp = s_bresp[p];
        s_bready[p] <= 1'b0;
        pend_w[p]   <= 1'b0;
        b_done = 1'b1;
      end else begin
        s_bready[p] <= next_bit();
      end
    end
    if (resp !== (addr[31] ? `RESP_SLVERR : `RESP_OKAY)) begin
      $display("Error at %0t: port %0d write %h got bresp %b", $time, p, addr, resp);
      err_cnt++;
    end
    // Shadow follows the write once its B is in
    if (!addr[31]) begin
      for (int b = 0; b < `DATA_W / 8; b++) begin
        if (strb[b]) shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    writes_done++;
  endtask

  task automatic do_read(input int p, input addr_t addr);
    logic r_done;
    r_done = 1'b0;
    @(posedge clk);
    s_arvalid[p] <= 1'b1;
    s_araddr[p]  <= addr;
    s_arprot[p]  <= addr[4:2];
    pend_r[p]    <= 1'b1;
    while (!r_done) begin
      @(posedge clk);
      if (s_arvalid[p] && s_arready[p]) s_arvalid[p] <= 1'b0;
      if (s_rvalid[p] && s_rready[p]) begin
        rd_port_q.push_back(p);
        rd_addr_q.push_back(addr);
        rd_data_q.push_back(s_rdata[p]);
        rd_resp_q.push_back(s_rresp[p]);
        s_rready[p] <= 1'b0;
        pend_r[p]   <= 1'b0;
        r_done = 1'b1;
      end else begin
        s_rready[p] <= next_bit();
      end
    end
  endtask

  // Write then read back inside the port's own region
  task automatic run_port(input int p);
    addr_t addr;
    for (int i = 0; i < N_PER_PORT; i++) begin
      addr      = '0;
      addr[31]  = (i % 8 == 5);
      addr[9:8] = p[1:0];
      addr[7:2] = 6'(rand_bits(6));
      do_write(p, addr, rand_bits(32), 4'(rand_bits(4)));
      repeat (rand_bits(2)) @(posedge clk);
      do_read(p, addr);
      repeat (rand_bits(2)) @(posedge clk);
    end
  endtask

  task automatic check_idle();
    if (m_awvalid || m_wvalid || m_arvalid) begin
      $display("Error at %0t: subordinate side valid high while idle", $time);
      err_cnt++;
    end
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (s_bvalid[p] || s_rvalid[p] || s_wready[p]) begin
        $display("Error at %0t: port %0d response or wready high while idle", $time, p);
        err_cnt++;
      end
    end
  endtask

  // --------------------
  // Read comparison
  initial begin : p_compare
    logic [33:0] exp;
    addr_t a;
    data_t d;
    resp_t r;
    int    p;
    forever begin
      wait (rd_addr_q.size() > 0);
      p   = rd_port_q.pop_front();
      a   = rd_addr_q.pop_front();
      d   = rd_data_q.pop_front();
      r   = rd_resp_q.pop_front();
      exp = expected_read(a);
      if (r !== exp[33:32]) begin
        $display("Error at %0t: port %0d read %h resp %b, expected %b",
                 $time, p, a, r, exp[33:32]);
        err_cnt++;
      end else if (r == `RESP_OKAY && d !== exp[31:0]) begin
        $display("Error at %0t: port %0d read %h data %h, expected %h",
                 $time, p, a, d, exp[31:0]);
        err_cnt++;
      end
      reads_checked++;
    end
  end

  // Address pass-through, response routing in grant order and outstanding counts
  always @(posedge clk) begin : p_route
    int exp_p;
    if (rst_n) begin
      for (int q = 0; q < `NUM_PORTS; q++) begin
        if (s_bvalid[q] && !pend_w[q]) begin
          $display("Port %0d received a write response it never asked for", q);
          err_cnt++;
        end
        if (s_rvalid[q] && !pend_r[q]) begin
          $display("Port %0d received read data it never asked for", q);
          err_cnt++;
        end
        // A granted address leaves unchanged in the same cycle
        if (s_awvalid[q] && s_awready[q]) begin
          aw_port_q.push_back(q);
          if (!(m_awvalid && m_awready) || m_awaddr !== s_awaddr[q] ||
              m_awprot !== s_awprot[q]) begin
            $display("Error at %0t: port %0d AW sent as %h prot %b, expected %h prot %b",
                     $time, q, m_awaddr, m_awprot, s_awaddr[q], s_awprot[q]);
            err_cnt++;
          end
        end
        if (s_arvalid[q] && s_arready[q]) begin
          ar_port_q.push_back(q);
          if (!(m_arvalid && m_arready) || m_araddr !== s_araddr[q] ||
              m_arprot !== s_arprot[q]) begin
            $display("Error at %0t: port %0d AR sent as %h prot %b, expected %h prot %b",
                     $time, q, m_araddr, m_arprot, s_araddr[q], s_arprot[q]);
            err_cnt++;
          end
        end
      end
      if (m_bvalid && m_bready) begin
        if (aw_port_q.size() == 0) begin
          $display("A write response came back with no write outstanding");
          err_cnt++;
        end else begin
          exp_p = aw_port_q.pop_front();
          for (int q = 0; q < `NUM_PORTS; q++) begin
            if (s_bvalid[q] !== (q == exp_p)) begin
              $display("Write response for port %0d showed bvalid %b on port %0d",
                       exp_p, s_bvalid[q], q);
              err_cnt++;
            end
          end
        end
      end
      if (m_rvalid && m_rready) begin
        if (ar_port_q.size() == 0) begin
          $display("Read data came back with no read outstanding");
          err_cnt++;
        end else begin
          exp_p = ar_port_q.pop_front();
          for (int q = 0; q < `NUM_PORTS; q++) begin
            if (s_rvalid[q] !== (q == exp_p)) begin
              $display("Read data for port %0d showed rvalid %b on port %0d",
                       exp_p, s_rvalid[q], q);
              err_cnt++;
            end
          end
        end
      end
      wr_out = wr_out + int'(m_awvalid && m_awready) - int'(m_bvalid && m_bready);
      rd_out = rd_out + int'(m_arvalid && m_arready) - int'(m_rvalid && m_rready);
      if (wr_out > wr_max) wr_max = wr_out;
      if (rd_out > rd_max) rd_max = rd_out;
    end
  end

  // Round robin check where skip[w][q] means q has waited since w last won
  always @(posedge clk) begin : p_fair
    int w;
    if (rst_n) begin
      for (int q = 0; q < `NUM_PORTS; q++) begin
        if (!s_awvalid[q]) begin
          for (int v = 0; v < `NUM_PORTS; v++) skip[v][q] = 1'b0;
        end
      end
      if (m_awvalid && m_awready) begin
        w = int'(m_awaddr[9:8]);
        for (int q = 0; q < `NUM_PORTS; q++) begin
          if (q != w && skip[w][q] && s_awvalid[q]) begin
            $display("Port %0d won AW twice while port %0d kept waiting", w, q);
            err_cnt++;
          end
          skip[q][w] = 1'b0;
          if (q != w) skip[w][q] = s_awvalid[q];
        end
      end
    end
  end

  // --------------------
  // Main sequence
  initial begin
    clk    = 1'b0;
    rst_n  = 1'b0;
    wr_out = 0;
    rd_out = 0;
    wr_max = 0;
    rd_max = 0;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      s_awvalid[p] = 1'b0;
      s_awaddr[p]  = '0;
      s_awprot[p]  = '0;
      s_wvalid[p]  = 1'b0;
      s_wdata[p]   = '0;
      s_wstrb[p]   = '0;
      s_bready[p]  = 1'b0;
      s_arvalid[p] = 1'b0;
      s_araddr[p]  = '0;
      s_arprot[p]  = '0;
      s_rready[p]  = 1'b0;
      pend_w[p]    = 1'b0;
      pend_r[p]    = 1'b0;
    end
    for (int i = 0; i < 256; i++) shadow[i] = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_idle();
    end
    // One port alone
    do_write(0, 32'h0000_0010, 32'hA5A5_1234, 4'hF);
    do_read(0, 32'h0000_0010);
    // All ports at once
    for (int p = 0; p < `NUM_PORTS; p++) begin
      automatic int q = p;
      fork
        run_port(q);
      join_none
    end
    wait fork;
    wait (rd_addr_q.size() == 0);
    repeat (4) @(posedge clk);
    if (wr_max < `MAX_TRANS || rd_max < `MAX_TRANS) begin
      $display("Outstanding depth never reached %0d (writes %0d, reads %0d)",
               `MAX_TRANS, wr_max, rd_max);
      err_cnt++;
    end
    $display("%0d writes, %0d reads checked, %0d errors", writes_done, reads_checked, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Run did not finish within %0d cycles, a transaction hung", WD_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
